// ==== lc3b_types.sv ====
package lc3b_types;

typedef logic [15:0] lc3b_word;

typedef logic [2:0] lc3b_reg;

// n z p from the msb down
typedef logic [2:0] lc3b_nzp;

// raw immediate and offset fields
typedef logic [4:0] lc3b_imm5;
typedef logic [5:0] lc3b_offset6;
typedef logic [8:0] lc3b_offset9;

// encodings follow the LC-3b ISA
typedef enum logic [3:0] {
	op_br  = 4'b0000,
	op_add = 4'b0001,
	op_and = 4'b0101,
	op_ldr = 4'b0110,
	op_str = 4'b0111,
	op_not = 4'b1001
} lc3b_opcode;

endpackage : lc3b_types

// ==== lc3b_pipe.sv ====
package lc3b_pipe;

typedef enum logic [1:0] {
	alu_add,
	alu_and,
	alu_not,
	alu_pass
} alu_op;

typedef struct packed {
	lc3b_types::lc3b_opcode opcode;
	alu_op aluop;
	logic imm_sel;
	logic load_regfile;
	logic load_cc;
	logic mem_read;
	logic mem_write;
	logic branch;
} control_word;

typedef struct packed {
	lc3b_types::lc3b_word npc;
	lc3b_types::lc3b_word ir;
	logic valid;
} f_de_t;

typedef struct packed {
	control_word cw;
	lc3b_types::lc3b_word npc;
	lc3b_types::lc3b_word ir;
	lc3b_types::lc3b_word opa;
	lc3b_types::lc3b_word opb;
	lc3b_types::lc3b_nzp nzp;
	lc3b_types::lc3b_reg dr;
	logic valid;
} de_ex_t;

typedef struct packed {
	control_word cw;
	lc3b_types::lc3b_word address;
	lc3b_types::lc3b_word result;
	lc3b_types::lc3b_word sdata;
	lc3b_types::lc3b_reg dr;
	logic valid;
} ex_mem_t;

typedef struct packed {
	control_word cw;
	lc3b_types::lc3b_word result;
	lc3b_types::lc3b_reg dr;
	logic valid;
} mem_wb_t;

typedef enum logic [1:0] {
	arb_idle,
	arb_inst,
	arb_data
} arb_state;

localparam lc3b_types::lc3b_word reset_pc = 16'h0000;
localparam int num_regs = 8;
localparam lc3b_types::lc3b_nzp cc_reset = 3'b010;

// a bubble writes nothing, accesses nothing and never branches
localparam control_word nop_cw = '{opcode: lc3b_types::op_br, aluop: alu_pass, default: 1'b0};

endpackage : lc3b_pipe

// ==== mem_port_if.sv ====
`timescale 1ns/1ns

interface mem_port_if;

	lc3b_types::lc3b_word address;
	logic read;
	logic write;
	lc3b_types::lc3b_word wdata;
	lc3b_types::lc3b_word rdata;
	logic resp;

	modport client (
		output address, read, write, wdata,
		input rdata, resp
	);

	modport server (
		input address, read, write, wdata,
		output rdata, resp
	);

endinterface : mem_port_if

// ==== arbiter.sv ====
`timescale 1ns/1ns

module arbiter (
	input logic clk,
	input logic rst_n,
	mem_port_if.server imem,
	mem_port_if.server dmem,
	input logic pmem_resp,
	input lc3b_types::lc3b_word pmem_rdata,
	output logic pmem_read,
	output logic pmem_write,
	output lc3b_types::lc3b_word pmem_address,
	output lc3b_types::lc3b_word pmem_wdata
);

	lc3b_pipe::arb_state state;
	lc3b_pipe::arb_state next_state;

	always_comb begin
		next_state = state;
		case (state)
			// data goes first since it belongs to the older instruction
			lc3b_pipe::arb_idle: begin
				if (dmem.read | dmem.write)
					next_state = lc3b_pipe::arb_data;
				else if (imem.read | imem.write)
					next_state = lc3b_pipe::arb_inst;
			end
			lc3b_pipe::arb_inst,
			lc3b_pipe::arb_data: begin
				if (pmem_resp)
					next_state = lc3b_pipe::arb_idle;
			end
			default: next_state = lc3b_pipe::arb_idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= lc3b_pipe::arb_idle;
		else
			state <= next_state;
	end

	always_comb begin
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		pmem_address = '0;
		pmem_wdata = '0;
		case (state)
			lc3b_pipe::arb_inst: begin
				pmem_read = imem.read;
				pmem_write = imem.write;
				pmem_address = imem.address;
				pmem_wdata = imem.wdata;
			end
			lc3b_pipe::arb_data: begin
				pmem_read = dmem.read;
				pmem_write = dmem.write;
				pmem_address = dmem.address;
				pmem_wdata = dmem.wdata;
			end
			default: ;
		endcase
	end

	// resp only to the client that holds the grant
	assign imem.resp = (state == lc3b_pipe::arb_inst) & pmem_resp;
	assign dmem.resp = (state == lc3b_pipe::arb_data) & pmem_resp;
	assign imem.rdata = pmem_rdata;
	assign dmem.rdata = pmem_rdata;

endmodule : arbiter

// ==== fetch.sv ====
`timescale 1ns/1ns

module fetch (
	input logic clk,
	input logic rst_n,
	input logic advance,
	input logic dep_stall,
	input logic redirect,
	input lc3b_types::lc3b_word target,
	mem_port_if.client imem,
	output lc3b_pipe::f_de_t f_de,
	output logic fetch_ready
);

	lc3b_types::lc3b_word pc;
	lc3b_types::lc3b_word req_addr;
	lc3b_types::lc3b_word buf_ir;
	lc3b_types::lc3b_word buf_npc;
	logic buf_valid;
	logic busy;
	logic gap;
	logic discard;
	logic take;
	logic jump;

	assign take = advance & ~dep_stall;
	assign jump = advance & redirect;
	assign fetch_ready = buf_valid;

	// next request goes out as soon as the buffer is handed to decode
	assign imem.read = busy | ((~buf_valid | take) & ~gap);
	assign imem.address = busy ? req_addr : pc;
	assign imem.write = 1'b0;
	assign imem.wdata = '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= lc3b_pipe::reset_pc;
			buf_valid <= 1'b0;
			busy <= 1'b0;
			gap <= 1'b0;
			discard <= 1'b0;
		end else begin
			busy <= imem.read & ~imem.resp;
			gap <= imem.resp;
			if (jump) begin
				pc <= target;
				buf_valid <= 1'b0;
				// a request raised this cycle still has to complete
				discard <= imem.read;
			end else if (imem.resp) begin
				if (discard) begin
					discard <= 1'b0;
				end else begin
					buf_valid <= 1'b1;
					pc <= imem.address + 16'd2;
				end
			end else if (take) begin
				buf_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!busy)
			req_addr <= pc;
		if (imem.resp && !discard) begin
			buf_ir <= imem.rdata;
			buf_npc <= imem.address + 16'd2;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			f_de.valid <= 1'b0;
		else if (jump)
			f_de.valid <= 1'b0;
		else if (take)
			f_de <= '{npc: buf_npc, ir: buf_ir, valid: buf_valid};
	end

endmodule : fetch

// ==== decode.sv ====
`timescale 1ns/1ns

module decode (
	input logic clk,
	input logic rst_n,
	input logic advance,
	input logic redirect,
	input lc3b_pipe::f_de_t f_de,
	input lc3b_pipe::de_ex_t de_ex_q,
	input lc3b_pipe::ex_mem_t ex_mem_q,
	input lc3b_pipe::mem_wb_t mem_wb,
	output lc3b_pipe::de_ex_t de_ex,
	output logic dep_stall
);

	lc3b_types::lc3b_word regfile [lc3b_pipe::num_regs];
	lc3b_types::lc3b_nzp cc;
	lc3b_types::lc3b_nzp wb_cc;
	lc3b_types::lc3b_opcode opcode;
	lc3b_pipe::control_word cw;
	lc3b_types::lc3b_reg sr1;
	lc3b_types::lc3b_reg sr2;
	logic use_sr1;
	logic use_sr2;
	logic use_cc;

	// does an older instruction still owe a register or the nzp we need
	function automatic logic conflict(
		input logic valid,
		input lc3b_pipe::control_word pcw,
		input lc3b_types::lc3b_reg pdr,
		input lc3b_types::lc3b_reg src_a,
		input logic use_a,
		input lc3b_types::lc3b_reg src_b,
		input logic use_b,
		input logic use_nzp
	);
		logic reg_hit;
		reg_hit = pcw.load_regfile && ((use_a && pdr == src_a) || (use_b && pdr == src_b));
		return valid && (reg_hit || (use_nzp && pcw.load_cc));
	endfunction

	always_comb begin
		opcode = lc3b_types::lc3b_opcode'(f_de.ir[15:12]);
		cw = lc3b_pipe::nop_cw;
		cw.opcode = opcode;
		sr1 = f_de.ir[8:6];
		sr2 = f_de.ir[2:0];
		use_sr1 = 1'b0;
		use_sr2 = 1'b0;
		use_cc = 1'b0;
		case (opcode)
			lc3b_types::op_add, lc3b_types::op_and: begin
				cw.aluop = (opcode == lc3b_types::op_add) ? lc3b_pipe::alu_add
				                                          : lc3b_pipe::alu_and;
				cw.imm_sel = f_de.ir[5];
				cw.load_regfile = 1'b1;
				cw.load_cc = 1'b1;
				use_sr1 = 1'b1;
				use_sr2 = ~f_de.ir[5];
			end
			lc3b_types::op_not: begin
				cw.aluop = lc3b_pipe::alu_not;
				cw.load_regfile = 1'b1;
				cw.load_cc = 1'b1;
				use_sr1 = 1'b1;
			end
			lc3b_types::op_ldr: begin
				cw.mem_read = 1'b1;
				cw.load_regfile = 1'b1;
				cw.load_cc = 1'b1;
				use_sr1 = 1'b1;
			end
			lc3b_types::op_str: begin
				// store data rides in operand B
				cw.mem_write = 1'b1;
				sr2 = f_de.ir[11:9];
				use_sr1 = 1'b1;
				use_sr2 = 1'b1;
			end
			lc3b_types::op_br: begin
				cw.branch = 1'b1;
				use_cc = 1'b1;
			end
			default: ;
		endcase
	end

	assign dep_stall = f_de.valid & (
		conflict(de_ex_q.valid, de_ex_q.cw, de_ex_q.dr, sr1, use_sr1, sr2, use_sr2, use_cc) |
		conflict(ex_mem_q.valid, ex_mem_q.cw, ex_mem_q.dr, sr1, use_sr1, sr2, use_sr2, use_cc) |
		conflict(mem_wb.valid, mem_wb.cw, mem_wb.dr, sr1, use_sr1, sr2, use_sr2, use_cc));

	assign wb_cc = mem_wb.result[15] ? 3'b100 : ((mem_wb.result == '0) ? 3'b010 : 3'b001);

	// write-back happens as the instruction leaves the pipe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < lc3b_pipe::num_regs; i++)
				regfile[i] <= '0;
			cc <= lc3b_pipe::cc_reset;
		end else if (advance && mem_wb.valid) begin
			if (mem_wb.cw.load_regfile)
				regfile[mem_wb.dr] <= mem_wb.result;
			if (mem_wb.cw.load_cc)
				cc <= wb_cc;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			de_ex.valid <= 1'b0;
			de_ex.cw <= lc3b_pipe::nop_cw;
		end else if (advance) begin
			if (redirect || dep_stall || !f_de.valid) begin
				de_ex.valid <= 1'b0;
				de_ex.cw <= lc3b_pipe::nop_cw;
			end else begin
				de_ex.cw <= cw;
				de_ex.npc <= f_de.npc;
				de_ex.ir <= f_de.ir;
				de_ex.opa <= regfile[sr1];
				de_ex.opb <= regfile[sr2];
				de_ex.nzp <= cc;
				de_ex.dr <= f_de.ir[11:9];
				de_ex.valid <= 1'b1;
			end
		end
	end

endmodule : decode

// ==== execute.sv ====
`timescale 1ns/1ns

module execute (
	input logic clk,
	input logic rst_n,
	input logic advance,
	input lc3b_pipe::de_ex_t de_ex,
	output lc3b_pipe::ex_mem_t ex_mem,
	output logic redirect,
	output lc3b_types::lc3b_word target
);

	lc3b_types::lc3b_imm5 imm5;
	lc3b_types::lc3b_offset6 offset6;
	lc3b_types::lc3b_offset9 offset9;
	lc3b_types::lc3b_word alu_b;
	lc3b_types::lc3b_word alu_out;
	lc3b_types::lc3b_word address;
	logic taken;

	assign imm5 = de_ex.ir[4:0];
	assign offset6 = de_ex.ir[5:0];
	assign offset9 = de_ex.ir[8:0];

	assign alu_b = de_ex.cw.imm_sel ? {{11{imm5[4]}}, imm5} : de_ex.opb;

	always_comb begin
		case (de_ex.cw.aluop)
			lc3b_pipe::alu_add: alu_out = de_ex.opa + alu_b;
			lc3b_pipe::alu_and: alu_out = de_ex.opa & alu_b;
			lc3b_pipe::alu_not: alu_out = ~de_ex.opa;
			default:            alu_out = alu_b;
		endcase
	end

	// offsets count words and are scaled by two
	assign address = de_ex.opa + {{9{offset6[5]}}, offset6, 1'b0};
	assign target = de_ex.npc + {{6{offset9[8]}}, offset9, 1'b0};

	assign taken = |(de_ex.ir[11:9] & de_ex.nzp);
	assign redirect = de_ex.valid & de_ex.cw.branch & taken;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_mem.valid <= 1'b0;
			ex_mem.cw <= lc3b_pipe::nop_cw;
		end else if (advance) begin
			if (!de_ex.valid) begin
				ex_mem.valid <= 1'b0;
				ex_mem.cw <= lc3b_pipe::nop_cw;
			end else begin
				ex_mem.cw <= de_ex.cw;
				ex_mem.address <= address;
				ex_mem.result <= alu_out;
				ex_mem.sdata <= de_ex.opb;
				ex_mem.dr <= de_ex.dr;
				ex_mem.valid <= 1'b1;
			end
		end
	end

endmodule : execute

// ==== mem_stage.sv ====
`timescale 1ns/1ns

module mem_stage (
	input logic clk,
	input logic rst_n,
	input logic advance,
	input lc3b_pipe::ex_mem_t ex_mem,
	mem_port_if.client dmem,
	output lc3b_pipe::mem_wb_t mem_wb,
	output logic mem_ready
);

	lc3b_types::lc3b_word rdata_q;
	logic access;
	logic done;

	assign access = ex_mem.valid & (ex_mem.cw.mem_read | ex_mem.cw.mem_write);

	// request drops once resp was seen, until the latch moves on
	assign dmem.read = access & ex_mem.cw.mem_read & ~done;
	assign dmem.write = access & ex_mem.cw.mem_write & ~done;
	assign dmem.address = ex_mem.address;
	assign dmem.wdata = ex_mem.sdata;

	assign mem_ready = ~access | done;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			done <= 1'b0;
		else if (advance)
			done <= 1'b0;
		else if (dmem.resp)
			done <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (dmem.resp)
			rdata_q <= dmem.rdata;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_wb.valid <= 1'b0;
			mem_wb.cw <= lc3b_pipe::nop_cw;
		end else if (advance) begin
			mem_wb.cw <= ex_mem.cw;
			mem_wb.result <= ex_mem.cw.mem_read ? rdata_q : ex_mem.result;
			mem_wb.dr <= ex_mem.dr;
			mem_wb.valid <= ex_mem.valid;
		end
	end

endmodule : mem_stage

// ==== mp3.sv ====
`timescale 1ns/1ns

module mp3 (
	input logic clk,
	input logic rst_n,
	input logic pmem_resp,
	input lc3b_types::lc3b_word pmem_rdata,
	output logic pmem_read,
	output logic pmem_write,
	output lc3b_types::lc3b_word pmem_address,
	output lc3b_types::lc3b_word pmem_wdata
);

	lc3b_pipe::f_de_t f_de;
	lc3b_pipe::de_ex_t de_ex;
	lc3b_pipe::ex_mem_t ex_mem;
	lc3b_pipe::mem_wb_t mem_wb;
	lc3b_types::lc3b_word target;
	logic redirect;
	logic dep_stall;
	logic fetch_ready;
	logic mem_ready;
	logic advance;

	mem_port_if imem ();
	mem_port_if dmem ();

	// every latch moves together
	assign advance = fetch_ready & mem_ready;

	fetch fetch_int (
		.clk, .rst_n, .advance, .dep_stall, .redirect, .target,
		.imem(imem.client), .f_de, .fetch_ready
	);

	decode decode_int (
		.clk, .rst_n, .advance, .redirect, .f_de,
		.de_ex_q(de_ex), .ex_mem_q(ex_mem), .mem_wb,
		.de_ex, .dep_stall
	);

	execute execute_int (
		.clk, .rst_n, .advance, .de_ex, .ex_mem, .redirect, .target
	);

	mem_stage mem_int (
		.clk, .rst_n, .advance, .ex_mem,
		.dmem(dmem.client), .mem_wb, .mem_ready
	);

	arbiter arbiter_int (
		.clk, .rst_n,
		.imem(imem.server), .dmem(dmem.server),
		.pmem_resp, .pmem_rdata,
		.pmem_read, .pmem_write, .pmem_address, .pmem_wdata
	);

endmodule : mp3

// ==== mp3_sva.sv ====
`timescale 1ns/1ns

module mp3_sva (
	input logic clk,
	input logic rst_n,
	input logic pmem_resp,
	input logic pmem_read,
	input logic pmem_write,
	input lc3b_types::lc3b_word pmem_address,
	input lc3b_types::lc3b_word pmem_wdata
);

	// a request only changes once memory has answered
	hold_until_resp: assert property (@(posedge clk) disable iff (!rst_n)
		(pmem_read || pmem_write) && !pmem_resp |=>
			$stable(pmem_read) && $stable(pmem_write) &&
			$stable(pmem_address) && $stable(pmem_wdata))
		else $error("physical request changed before resp");

	read_write_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(pmem_read && pmem_write))
		else $error("pmem_read and pmem_write high together");

	quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !pmem_read && !pmem_write)
		else $error("physical request during reset");

endmodule : mp3_sva

// ==== mp3_tb.sv ====
`timescale 1ns/1ns

module mp3_tb;

	localparam int cycle_limit = 20000;
	localparam int mem_words = 32768;

	logic clk;
	logic rst_n;
	logic pmem_resp;
	lc3b_types::lc3b_word pmem_rdata;
	logic pmem_read;
	logic pmem_write;
	lc3b_types::lc3b_word pmem_address;
	lc3b_types::lc3b_word pmem_wdata;

	lc3b_types::lc3b_word mem [mem_words];
	lc3b_types::lc3b_word ref_mem [mem_words];
	lc3b_types::lc3b_word exp_addr [$];
	lc3b_types::lc3b_word exp_data [$];
	logic [31:0] lfsr = 32'h6f4f310b;
	int wr_ptr;
	int stores_seen = 0;

	mp3 mp3_inst (
		.clk, .rst_n, .pmem_resp, .pmem_rdata,
		.pmem_read, .pmem_write, .pmem_address, .pmem_wdata
	);

	bind arbiter mp3_sva arbiter_sva (
		.clk, .rst_n, .pmem_resp,
		.pmem_read, .pmem_write, .pmem_address, .pmem_wdata
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	// taps 32 22 2 1
	function automatic logic random_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic lc3b_types::lc3b_word alu_reg(input lc3b_types::lc3b_opcode op,
			input int dr, input int sr1, input int sr2);
		return {op, 3'(dr), 3'(sr1), 3'b000, 3'(sr2)};
	endfunction

	function automatic lc3b_types::lc3b_word alu_imm(input lc3b_types::lc3b_opcode op,
			input int dr, input int sr, input int imm);
		return {op, 3'(dr), 3'(sr), 1'b1, 5'(imm)};
	endfunction

	function automatic lc3b_types::lc3b_word not_reg(input int dr, input int sr);
		return {lc3b_types::op_not, 3'(dr), 3'(sr), 6'b111111};
	endfunction

	function automatic lc3b_types::lc3b_word mem_op(input lc3b_types::lc3b_opcode op,
			input int r, input int base, input int off);
		return {op, 3'(r), 3'(base), 6'(off)};
	endfunction

	function automatic lc3b_types::lc3b_word br_op(input int nzp, input int off);
		return {lc3b_types::op_br, 3'(nzp), 9'(off)};
	endfunction

	task automatic emit(input lc3b_types::lc3b_word w);
		mem[wr_ptr] = w;
		wr_ptr++;
	endtask

	task automatic load_memory();
		for (int i = 0; i < mem_words; i++)
			mem[i] = 16'(i) ^ 16'hc35a;
		// data block at 0xffc0 that r0 reaches with a negative offset
		mem[15'h7fe0] = 16'hffc0;
		mem[15'h7fe1] = 16'h1234;
		mem[15'h7fe2] = 16'h8001;
		wr_ptr = 0;
		// each arithmetic result leans on the one before
		emit(alu_imm(lc3b_types::op_add, 1, 0, 5));
		emit(alu_imm(lc3b_types::op_add, 2, 1, -3));
		emit(alu_reg(lc3b_types::op_add, 3, 1, 2));
		emit(alu_imm(lc3b_types::op_and, 4, 3, 6));
		emit(alu_reg(lc3b_types::op_and, 5, 3, 4));
		emit(not_reg(7, 5));
		emit(mem_op(lc3b_types::op_ldr, 6, 0, -32));
		emit(mem_op(lc3b_types::op_str, 1, 6, 16));
		emit(mem_op(lc3b_types::op_str, 2, 6, 17));
		emit(mem_op(lc3b_types::op_str, 3, 6, 18));
		emit(mem_op(lc3b_types::op_str, 4, 6, 19));
		emit(mem_op(lc3b_types::op_str, 5, 6, 20));
		emit(mem_op(lc3b_types::op_str, 7, 6, 21));
		// hazards at distance one, two and three
		emit(alu_reg(lc3b_types::op_add, 1, 1, 1));
		emit(alu_imm(lc3b_types::op_add, 2, 2, 1));
		emit(alu_reg(lc3b_types::op_add, 3, 1, 2));
		emit(alu_imm(lc3b_types::op_add, 4, 0, 9));
		emit(alu_imm(lc3b_types::op_add, 5, 0, 1));
		emit(alu_imm(lc3b_types::op_add, 7, 0, -1));
		emit(alu_reg(lc3b_types::op_add, 4, 4, 4));
		emit(mem_op(lc3b_types::op_str, 3, 6, 22));
		emit(mem_op(lc3b_types::op_str, 4, 6, 23));
		// loads and then a reload of a fresh store
		emit(mem_op(lc3b_types::op_ldr, 1, 6, 1));
		emit(mem_op(lc3b_types::op_ldr, 2, 6, 2));
		emit(alu_reg(lc3b_types::op_add, 3, 1, 2));
		emit(mem_op(lc3b_types::op_str, 3, 6, 24));
		emit(mem_op(lc3b_types::op_str, 2, 6, 25));
		emit(mem_op(lc3b_types::op_ldr, 4, 6, 24));
		emit(alu_imm(lc3b_types::op_add, 4, 4, 1));
		emit(mem_op(lc3b_types::op_str, 4, 0, -1));
		// n, z and p in turn against all eight masks
		emit(alu_imm(lc3b_types::op_add, 5, 6, -16));
		for (int g = 0; g < 3; g++) begin
			emit(alu_imm(lc3b_types::op_add, 7, 0, g - 1));
			for (int m = 0; m < 8; m++) begin
				emit(br_op(m, 1));
				emit(mem_op(lc3b_types::op_str, 7, 5, g * 8 + m));
			end
		end
		// backward branch that makes three passes
		emit(alu_imm(lc3b_types::op_add, 1, 0, 3));
		emit(alu_imm(lc3b_types::op_add, 1, 1, -1));
		emit(mem_op(lc3b_types::op_str, 1, 5, 24));
		emit(br_op(3'b001, -3));
		emit(br_op(3'b111, -1));
		ref_mem = mem;
	endtask

	// ISA level run up to the self loop
	function automatic void ref_run();
		lc3b_types::lc3b_word r [8];
		lc3b_types::lc3b_word pc;
		lc3b_types::lc3b_word ir;
		lc3b_types::lc3b_word src2;
		lc3b_types::lc3b_word res;
		lc3b_types::lc3b_word ea;
		lc3b_types::lc3b_nzp cc;
		logic writes_reg;
		pc = 16'h0000;
		cc = 3'b010;
		foreach (r[i])
			r[i] = '0;
		for (int step = 0; step < 10000; step++) begin
			ir = ref_mem[pc[15:1]];
			pc = pc + 16'd2;
			writes_reg = 1'b1;
			src2 = ir[5] ? {{11{ir[4]}}, ir[4:0]} : r[ir[2:0]];
			ea = r[ir[8:6]] + {{9{ir[5]}}, ir[5:0], 1'b0};
			case (lc3b_types::lc3b_opcode'(ir[15:12]))
				lc3b_types::op_add: res = r[ir[8:6]] + src2;
				lc3b_types::op_and: res = r[ir[8:6]] & src2;
				lc3b_types::op_not: res = ~r[ir[8:6]];
				lc3b_types::op_ldr: res = ref_mem[ea[15:1]];
				lc3b_types::op_str: begin
					ref_mem[ea[15:1]] = r[ir[11:9]];
					exp_addr.push_back(ea);
					exp_data.push_back(r[ir[11:9]]);
					writes_reg = 1'b0;
				end
				lc3b_types::op_br: begin
					writes_reg = 1'b0;
					if ((ir[11:9] & cc) != 3'b000) begin
						if (ir[8:0] == 9'h1ff)
							return;
						pc = pc + {{6{ir[8]}}, ir[8:0], 1'b0};
					end
				end
				default: writes_reg = 1'b0;
			endcase
			if (writes_reg) begin
				r[ir[11:9]] = res;
				cc = res[15] ? 3'b100 : ((res == '0) ? 3'b010 : 3'b001);
			end
		end
	endfunction

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// answers after 0 to 3 extra cycles
	initial begin : memory_model
		int delay;
		logic pending;
		logic resp_now;
		pmem_resp = 1'b0;
		pmem_rdata = '0;
		pending = 1'b0;
		delay = 0;
		forever begin
			@(posedge clk);
			#2;
			resp_now = 1'b0;
			if (pmem_read || pmem_write) begin
				if (!pending) begin
					pending = 1'b1;
					delay = random_bit();
					delay = 2 * delay + random_bit();
				end
				if (delay == 0) begin
					resp_now = 1'b1;
					pending = 1'b0;
					if (pmem_read)
						pmem_rdata = mem[pmem_address[15:1]];
					else
						mem[pmem_address[15:1]] = pmem_wdata;
				end else begin
					delay--;
				end
			end
			pmem_resp = resp_now;
		end
	end

	initial begin : store_checker
		forever begin
			@(negedge clk);
			if (pmem_write && pmem_resp) begin
				assert (stores_seen < exp_addr.size()) else
					abort_run("a store arrived after the last expected store");
				assert (pmem_address == exp_addr[stores_seen]) else
					abort_run($sformatf("error: pmem_address expected %h actual %h",
						exp_addr[stores_seen], pmem_address));
				assert (pmem_wdata == exp_data[stores_seen]) else
					abort_run($sformatf("error: pmem_wdata expected %h actual %h",
						exp_data[stores_seen], pmem_wdata));
				stores_seen++;
			end
		end
	end

	initial begin
		int waited;
		rst_n = 1'b0;
		load_memory();
		ref_run();
		repeat (2) @(posedge clk);
		#2;
		rst_n = 1'b1;
		waited = 0;
		while (stores_seen < exp_addr.size() && waited < cycle_limit) begin
			@(posedge clk);
			waited++;
		end
		if (stores_seen < exp_addr.size()) begin
			abort_run($sformatf("timeout: only %0d of %0d stores arrived, the pipeline stalled",
				stores_seen, exp_addr.size()));
		end else begin
			$display("*** PASSED ***");
			$finish;
		end
	end

endmodule : mp3_tb

// ==== files.f ====
lc3b_types.sv
lc3b_pipe.sv
mem_port_if.sv
arbiter.sv
fetch.sv
decode.sv
execute.sv
mem_stage.sv
mp3.sv
mp3_sva.sv
mp3_tb.sv

// ==== Bender.yml ====
package:
  name: mp3

sources:
  - lc3b_types.sv
  - lc3b_pipe.sv
  - mem_port_if.sv
  - arbiter.sv
  - fetch.sv
  - decode.sv
  - execute.sv
  - mem_stage.sv
  - mp3.sv
  - target: test
    files:
      - mp3_sva.sv
      - mp3_tb.sv
